// File: fir_regmap_pkg.sv
// register map of the fir control slave: addresses, bit positions and the write word views
package fir_regmap_pkg;

    // axi4-lite byte address and data word
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // block-level control word
    localparam axil_addr_t ADDR_AP_CTRL  = 12'h000;
    // tap i sits at base + 4*i
    localparam axil_addr_t ADDR_TAP_BASE = 12'h020;

    // control word bit positions
    localparam int unsigned AP_START_BIT = 0;
    localparam int unsigned AP_DONE_BIT  = 1;
    localparam int unsigned AP_IDLE_BIT  = 2;

    // control view, lsb first from the bottom
    typedef struct packed {
        logic [28:0] reserved;
        logic        ap_idle;
        logic        ap_done;
        logic        ap_start;
    } ctrl_bits_t;

    // one write word, two meanings
    // control bits at 0x00, signed coefficient in the tap region
    typedef union packed {
        ctrl_bits_t         ctrl;
        logic signed [31:0] coef;
    } ctrl_word_u;

endpackage

// File: fir_dsp_pkg.sv
// datapath types of the fir filter: samples, coefficients and the wrapping accumulator
package fir_dsp_pkg;

    // stream sample width
    localparam int DATA_W = 32;
    // accumulator width, same as data so sums wrap
    localparam int ACC_W  = 32;

    // signed sample on both streams
    typedef logic signed [DATA_W-1:0] sample_t;

    // signed tap coefficient
    typedef logic signed [DATA_W-1:0] coef_t;

    // product and running sum
    // no guard bits, overflow wraps modulo 2^32
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// File: axil_slave.sv
// axi4-lite slave that serializes reads and writes into single-cycle register strobes
module axil_slave import fir_regmap_pkg::*; (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    // write address and data
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    // write response
    output logic       bvalid,
    input  logic       bready,
    // read address and data
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    // register side
    output logic       reg_wr_en,
    output axil_addr_t reg_wr_addr,
    output axil_data_t reg_wr_data,
    output logic       reg_rd_en,
    output axil_addr_t reg_rd_addr,
    input  axil_data_t reg_rd_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_ACK,
        S_WR_RESP,
        S_RD_ACK,
        S_RD_WAIT,
        S_RD_RESP
    } state_t;

    state_t     state;
    state_t     state_next;
    axil_addr_t wr_addr_q;
    axil_data_t wr_data_q;
    axil_addr_t rd_addr_q;

    // one transaction at a time, read wins a tie
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (arvalid) begin
                    state_next = S_RD_ACK;
                end else if (awvalid && wvalid) begin
                    state_next = S_WR_ACK;
                end
            end
            // source holds valid, so the ready cycle is the handshake
            S_WR_ACK:  state_next = S_WR_RESP;
            S_WR_RESP: if (bready) state_next = S_IDLE;
            S_RD_ACK:  state_next = S_RD_WAIT;
            // register file answers one cycle after the strobe
            S_RD_WAIT: state_next = S_RD_RESP;
            S_RD_RESP: if (rready) state_next = S_IDLE;
            default:   state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // capture address and data as the request is taken
    always_ff @(posedge axis_clk) begin
        if (state == S_IDLE && state_next == S_WR_ACK) begin
            wr_addr_q <= awaddr;
            wr_data_q <= wdata;
        end
        if (state == S_IDLE && state_next == S_RD_ACK) begin
            rd_addr_q <= araddr;
        end
        // read data held until rready
        if (state == S_RD_WAIT) begin
            rdata <= reg_rd_data;
        end
    end

    // handshake outputs straight from the state
    assign awready = (state == S_WR_ACK);
    assign wready  = (state == S_WR_ACK);
    assign bvalid  = (state == S_WR_RESP);
    assign arready = (state == S_RD_ACK);
    assign rvalid  = (state == S_RD_RESP);

    // strobes land in the handshake cycle
    assign reg_wr_en   = (state == S_WR_ACK);
    assign reg_wr_addr = wr_addr_q;
    assign reg_wr_data = wr_data_q;
    assign reg_rd_en   = (state == S_RD_ACK);
    assign reg_rd_addr = rd_addr_q;

endmodule

// File: fir_ctrl_regs.sv
// fir control registers: ap_start/ap_done/ap_idle word, tap coefficients and read-back
module fir_ctrl_regs
    import fir_regmap_pkg::*;
    import fir_dsp_pkg::*;
#(
    parameter int NUM_TAPS = 11
) (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 reg_wr_en,
    input  axil_addr_t           reg_wr_addr,
    input  axil_data_t           reg_wr_data,
    input  logic                 reg_rd_en,
    input  axil_addr_t           reg_rd_addr,
    output axil_data_t           reg_rd_data,
    input  logic                 start_ack,
    input  logic                 run_done,
    output logic                 ap_start,
    output coef_t [NUM_TAPS-1:0] taps
);

    localparam int TAP_IDX_W = $clog2(NUM_TAPS);

    logic       ap_done;
    logic       ap_idle;
    ctrl_word_u wr_word;
    logic       ctrl_wr;
    logic       ctrl_rd;
    logic       tap_wr;
    axil_data_t rd_word;

    // word aligned and inside the tap window
    function automatic logic tap_hit(input axil_addr_t addr);
        axil_addr_t off;
        off = addr - ADDR_TAP_BASE;
        return (addr >= ADDR_TAP_BASE) && (off[1:0] == 2'b00)
            && ((off >> 2) < axil_addr_t'(NUM_TAPS));
    endfunction

    function automatic logic [TAP_IDX_W-1:0] tap_index(input axil_addr_t addr);
        axil_addr_t off;
        off = addr - ADDR_TAP_BASE;
        return off[TAP_IDX_W+1:2];
    endfunction

    // same bits, viewed by region
    assign wr_word = reg_wr_data;

    assign ctrl_wr = reg_wr_en && (reg_wr_addr == ADDR_AP_CTRL);
    assign ctrl_rd = reg_rd_en && (reg_rd_addr == ADDR_AP_CTRL);
    assign tap_wr  = reg_wr_en && tap_hit(reg_wr_addr);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            taps     <= '0;
        end else begin
            // first sample taken, block is busy
            if (start_ack) begin
                ap_start <= 1'b0;
                ap_idle  <= 1'b0;
            end else if (ctrl_wr && ap_idle) begin
                ap_start <= wr_word.ctrl.ap_start;
            end
            // last output left, done wins over a read clear
            if (run_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (ctrl_rd) begin
                ap_done <= 1'b0;
            end
            // coefficients locked while running
            if (tap_wr && ap_idle) begin
                taps[tap_index(reg_wr_addr)] <= wr_word.coef;
            end
        end
    end

    // read-back select, unmapped reads as zero
    always_comb begin
        rd_word = '0;
        if (reg_rd_addr == ADDR_AP_CTRL) begin
            rd_word[AP_START_BIT] = ap_start;
            rd_word[AP_DONE_BIT]  = ap_done;
            rd_word[AP_IDLE_BIT]  = ap_idle;
        end else if (tap_hit(reg_rd_addr)) begin
            rd_word = taps[tap_index(reg_rd_addr)];
        end
    end

    // value as it was before the ap_done clear
    always_ff @(posedge axis_clk) begin
        if (reg_rd_en) begin
            reg_rd_data <= rd_word;
        end
    end

endmodule

// File: fir_engine.sv
// fir datapath: sample history ring and one shared multiply-accumulate over all taps
module fir_engine import fir_dsp_pkg::*; #(
    parameter int NUM_TAPS = 11
) (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 ap_start,
    input  coef_t [NUM_TAPS-1:0] taps,
    // input stream
    input  logic                 ss_tvalid,
    output logic                 ss_tready,
    input  sample_t              ss_tdata,
    input  logic                 ss_tlast,
    // output stream
    output logic                 sm_tvalid,
    input  logic                 sm_tready,
    output sample_t              sm_tdata,
    output logic                 sm_tlast,
    // to the control word
    output logic                 start_ack,
    output logic                 run_done
);

    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TAPS - 1);

    sample_t          hist [NUM_TAPS];
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] wr_ptr;
    logic [IDX_W-1:0] rd_ptr;
    logic [IDX_W-1:0] tap_idx;
    logic             running;
    logic             busy;
    logic             last_in;
    logic             accept;
    logic             final_step;
    logic             out_load;
    acc_t             acc;
    acc_t             prod;
    acc_t             sum;

    function automatic logic [IDX_W-1:0] ring_next(input logic [IDX_W-1:0] p);
        return (p == LAST_IDX) ? '0 : p + 1'b1;
    endfunction

    function automatic logic [IDX_W-1:0] ring_prev(input logic [IDX_W-1:0] p);
        return (p == '0) ? LAST_IDX : p - 1'b1;
    endfunction

    // take a sample only with the mac free and before tlast was seen
    assign ss_tready = !busy && !last_in && (ap_start || running);
    assign accept    = ss_tvalid && ss_tready;
    assign start_ack = accept && !running;

    // a new run restarts the ring at slot 0
    assign wr_ptr = running ? ring_next(head) : '0;

    // tap i times the sample i back
    assign prod = taps[tap_idx] * hist[rd_ptr];
    assign sum  = acc + prod;

    // last tap waits here while the output is held
    assign final_step = busy && (tap_idx == LAST_IDX);
    assign out_load   = final_step && (!sm_tvalid || sm_tready);

    assign run_done = sm_tvalid && sm_tready && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            running   <= 1'b0;
            busy      <= 1'b0;
            last_in   <= 1'b0;
            head      <= '0;
            rd_ptr    <= '0;
            tap_idx   <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            if (accept) begin
                running <= 1'b1;
                busy    <= 1'b1;
                // also blocks further input until the run ends
                last_in <= ss_tlast;
                head    <= wr_ptr;
                rd_ptr  <= wr_ptr;
                tap_idx <= '0;
            end else if (busy && !final_step) begin
                // walk back through the history
                tap_idx <= tap_idx + 1'b1;
                rd_ptr  <= ring_prev(rd_ptr);
            end else if (out_load) begin
                busy <= 1'b0;
            end
            // output register
            if (out_load) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= last_in;
            end else if (sm_tready) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
            // tlast result taken downstream
            if (run_done) begin
                running <= 1'b0;
                last_in <= 1'b0;
            end
        end
    end

    // accumulator and result word
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc <= '0;
        end else if (busy && !final_step) begin
            acc <= sum;
        end
        if (out_load) begin
            sm_tdata <= sum;
        end
    end

    // history ring, zero history at the start of a run
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                if (IDX_W'(i) == wr_ptr) begin
                    hist[i] <= ss_tdata;
                end else if (!running) begin
                    hist[i] <= '0;
                end
            end
        end
    end

endmodule

// File: fir_top.sv
// fir filter top: axi4-lite control slave, control registers and the stream engine
module fir_top
    import fir_regmap_pkg::*;
    import fir_dsp_pkg::*;
#(
    parameter int NUM_TAPS = 11
) (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    // axi4-lite write
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    output logic       bvalid,
    input  logic       bready,
    // axi4-lite read
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    // input stream
    input  logic       ss_tvalid,
    output logic       ss_tready,
    input  sample_t    ss_tdata,
    input  logic       ss_tlast,
    // output stream
    output logic       sm_tvalid,
    input  logic       sm_tready,
    output sample_t    sm_tdata,
    output logic       sm_tlast
);

    // register strobes
    logic       reg_wr_en;
    axil_addr_t reg_wr_addr;
    axil_data_t reg_wr_data;
    logic       reg_rd_en;
    axil_addr_t reg_rd_addr;
    axil_data_t reg_rd_data;

    // control to engine
    logic                 ap_start;
    coef_t [NUM_TAPS-1:0] taps;
    logic                 start_ack;
    logic                 run_done;

    axil_slave u_axil (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .bvalid      (bvalid),
        .bready      (bready),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .reg_rd_en   (reg_rd_en),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_data (reg_rd_data)
    );

    fir_ctrl_regs #(
        .NUM_TAPS (NUM_TAPS)
    ) u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .reg_rd_en   (reg_rd_en),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_data (reg_rd_data),
        .start_ack   (start_ack),
        .run_done    (run_done),
        .ap_start    (ap_start),
        .taps        (taps)
    );

    fir_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ap_start   (ap_start),
        .taps       (taps),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .start_ack  (start_ack),
        .run_done   (run_done)
    );

endmodule

// File: fir_props.sv
// handshake checks for the fir top: output and read data hold, no input taken while idle
module fir_props (
    input logic        axis_clk,
    input logic        axis_rst_n,
    input logic        sm_tvalid,
    input logic        sm_tready,
    input logic [31:0] sm_tdata,
    input logic        sm_tlast,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        ss_tready,
    input logic        ap_start,
    input logic        ap_idle
);

    // failures seen by the testbench at the end of the run
    int assert_errors = 0;

    // output word stays put until the sink takes it
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else begin
            $error("sm_tvalid dropped or sm_tdata changed before sm_tready");
            assert_errors++;
        end

    // read response held under back-pressure
    r_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid dropped or rdata changed before rready");
            assert_errors++;
        end

    // idle and not started, so the input stream is closed
    idle_closed: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ap_idle && !ap_start |-> !ss_tready)
        else begin
            $error("ss_tready high while idle without ap_start");
            assert_errors++;
        end

endmodule

bind fir_top fir_props u_props (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tready  (ss_tready),
    .ap_start   (ap_start),
    .ap_idle    (u_regs.ap_idle)
);

// File: fir_tb.sv
// fir testbench: programs taps over axi4-lite, streams samples and checks the filtered outputs
module fir_tb import fir_regmap_pkg::*; ();

    localparam int NUM_TAPS       = 11;
    localparam int NUM_SAMPLES    = 16;
    localparam int STIM_WORDS     = NUM_TAPS + 3 * NUM_SAMPLES;
    localparam int TIMEOUT_CYCLES = NUM_SAMPLES * (NUM_TAPS + 1) * 4 + 400;
    localparam int READY_PAT_LEN  = 256;
    // tap rewritten while the run is busy
    localparam int LOCKED_TAP     = 4;

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid;
    logic        awready;
    axil_addr_t  awaddr;
    logic        wvalid;
    logic        wready;
    axil_data_t  wdata;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    axil_addr_t  araddr;
    logic        rvalid;
    logic        rready;
    axil_data_t  rdata;
    logic        ss_tvalid;
    logic        ss_tready;
    logic [31:0] ss_tdata;
    logic        ss_tlast;
    logic        sm_tvalid;
    logic        sm_tready;
    logic [31:0] sm_tdata;
    logic        sm_tlast;

    // taps, then sample / tlast / expected triplets
    logic [31:0] stim_mem [STIM_WORDS];
    int unsigned ss_gap [NUM_SAMPLES];
    logic        ready_pat [READY_PAT_LEN];
    int          error_count;
    int          check_count;
    int          cycle_count;
    logic        first_taken;

    fir_top #(
        .NUM_TAPS (NUM_TAPS)
    ) uut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    initial begin
        axis_clk = 1'b0;
        forever #2 axis_clk = ~axis_clk;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge axis_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] stim_sample(input int k);
        return stim_mem[NUM_TAPS + 3 * k];
    endfunction

    function automatic logic [31:0] stim_last(input int k);
        return stim_mem[NUM_TAPS + 3 * k + 1];
    endfunction

    function automatic logic [31:0] stim_expect(input int k);
        return stim_mem[NUM_TAPS + 3 * k + 2];
    endfunction

    function automatic axil_addr_t tap_addr(input int i);
        return axil_addr_t'(ADDR_TAP_BASE + 4 * i);
    endfunction

    // drive point, just past the rising edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bready held high, so the response goes in one cycle
    task automatic bus_write(input axil_addr_t addr, input axil_data_t data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) next_cycle();
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) next_cycle();
        next_cycle();
    endtask

    // read response stalled two cycles before rready
    task automatic bus_read(input axil_addr_t addr, output axil_data_t data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        while (!rvalid) next_cycle();
        repeat (2) next_cycle();
        rready = 1'b1;
        data   = rdata;
        next_cycle();
    endtask

    // samples with random idle gaps between them
    task automatic drive_stream();
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            repeat (ss_gap[k]) next_cycle();
            ss_tdata  = stim_sample(k);
            ss_tlast  = stim_last(k)[0];
            ss_tvalid = 1'b1;
            while (!ss_tready) next_cycle();
            next_cycle();
            ss_tvalid   = 1'b0;
            ss_tlast    = 1'b0;
            first_taken = 1'b1;
        end
    endtask

    // sink with a random ready pattern, checks each word as it is taken
    task automatic collect_outputs();
        int count;
        int pat_idx;
        count   = 0;
        pat_idx = 0;
        while (count < NUM_SAMPLES) begin
            sm_tready = ready_pat[pat_idx % READY_PAT_LEN];
            pat_idx++;
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("output %0d data", count), sm_tdata, stim_expect(count));
                check_value($sformatf("output %0d tlast", count), {31'b0, sm_tlast},
                            stim_last(count));
                count++;
            end
            next_cycle();
        end
        sm_tready = 1'b1;
    endtask

    // control word busy state, then a tap write that must not land
    task automatic probe_busy_regs();
        axil_data_t val;
        while (!first_taken) next_cycle();
        bus_read(ADDR_AP_CTRL, val);
        check_value("control word after first sample", val, 32'h0);
        bus_write(tap_addr(LOCKED_TAP), 32'h0000_1234);
        bus_read(tap_addr(LOCKED_TAP), val);
        check_value("tap written while running", val, stim_mem[LOCKED_TAP]);
    endtask

    initial begin
        axil_data_t  val;
        int unsigned seed_ret;
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b1;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b1;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b0;
        error_count = 0;
        check_count = 0;
        first_taken = 1'b0;
        seed_ret = $urandom(32'he65d1c3f);
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            ss_gap[k] = $urandom % 4;
        end
        for (int i = 0; i < READY_PAT_LEN; i++) begin
            ready_pat[i] = ($urandom % 3) != 0;
        end
        $readmemh("fir_stimulus.txt", stim_mem);
        repeat (8) @(posedge axis_clk);
        #1 axis_rst_n = 1'b1;
        next_cycle();
        // idle after reset
        bus_read(ADDR_AP_CTRL, val);
        check_value("control word after reset", val, 32'h4);
        for (int i = 0; i < NUM_TAPS; i++) begin
            bus_write(tap_addr(i), stim_mem[i]);
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            bus_read(tap_addr(i), val);
            check_value($sformatf("tap %0d read-back", i), val, stim_mem[i]);
        end
        bus_write(ADDR_AP_CTRL, 32'h1);
        fork
            drive_stream();
            collect_outputs();
            probe_busy_regs();
        join
        // done and idle, then done cleared by the first read
        bus_read(ADDR_AP_CTRL, val);
        check_value("control word after run", val, 32'h6);
        bus_read(ADDR_AP_CTRL, val);
        check_value("control word after done read", val, 32'h4);
        repeat (4) next_cycle();
        $display("checks run: %0d, check errors: %0d, assertion errors: %0d",
                 check_count, error_count, uut.u_props.assert_errors);
        if (error_count == 0 && uut.u_props.assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: fir_stimulus.txt
// fir stimulus: first 11 words are the taps 0..10, one per line
// then one line per sample with columns: sample, tlast, expected output (32-bit hex)
00000003
ffffffff
00000002
00000000
00000005
fffffffe
00000001
00000004
fffffffd
00000002
00000001
00000001 0 00000003
00000002 0 00000005
ffffffff 0 fffffffd
00000003 0 0000000e
00000000 0 00000000
00000004 0 0000001a
fffffffe 0 ffffffee
00000005 0 00000030
00000001 0 fffffff8
fffffffd 0 0000000f
00000002 0 0000000d
00000006 0 00000022
ffffffff 0 00000009
00000000 0 fffffff0
00000003 0 0000003a
00000007 1 0000001e

// File: files.f
fir_regmap_pkg.sv
fir_dsp_pkg.sv
axil_slave.sv
fir_ctrl_regs.sv
fir_engine.sv
fir_top.sv
fir_props.sv
fir_tb.sv
